// ==== common/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

	// Byte address as seen on the write-back pc and the memory read channel
	typedef logic [31:0] addr_t;

	typedef logic [31:0] inst_t;

	// One beat of the 64-bit memory read channel
	typedef logic [63:0] beat_t;

	typedef logic [1:0] resp_t;

	// Bit 1 of a read response flags an error
	localparam int RESP_ERR_BIT = 1;

	// On-chip SRAM window, served without the cache
	localparam addr_t SRAM_BASE  = 32'h0f000000;
	localparam addr_t SRAM_LIMIT = 32'h0f002000;

	typedef logic [15:0] count_t;

	localparam count_t COUNT_MAX = '1;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		CHECK,
		MEM_REQ,
		MEM_WAIT,
		FILL,
		DELIVER
	} fetch_state_t;

endpackage

`default_nettype wire

// ==== common/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

	localparam int ADDR_W = 32;

	// Lines hold a single 32-bit word
	localparam int LINE_BYTES_LOG = 2;

	// The real index width follows the line count up to this bound
	localparam int INDEX_MAX_W = 10;

	// Tag keeps everything above the line offset; high bits beyond the index shift stay zero
	localparam int TAG_W = ADDR_W - LINE_BYTES_LOG;

	typedef logic [INDEX_MAX_W-1:0] index_t;

	typedef logic [TAG_W-1:0] tag_t;

endpackage

`default_nettype wire

// ==== fetch/inst_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_select (
	input  wire fetch_pkg::addr_t pc,
	input  wire fetch_pkg::beat_t rdata,

	output logic                  in_sram,
	output fetch_pkg::inst_t      sel_word
);
	import fetch_pkg::*;

	logic upper_lane;

	assign in_sram = (pc >= SRAM_BASE) && (pc < SRAM_LIMIT);

	// SRAM returns the aligned 8-byte pair and pc bit 2 picks the word
	// Cached reads always come back in the lower lane
	assign upper_lane = in_sram && pc[2];

	assign sel_word = upper_lane ? rdata[63:32] : rdata[31:0];

endmodule

`default_nettype wire

// ==== fetch/fetch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
	input  wire                    clock,
	input  wire                    rst_n,

	input  wire                    wb_valid,
	input  wire fetch_pkg::addr_t  pc,

	input  wire                    in_sram,
	input  wire                    cache_hit,
	input  wire                    cache_miss,
	input  wire fetch_pkg::inst_t  cache_data,
	input  wire fetch_pkg::inst_t  sel_word,

	output fetch_pkg::addr_t       mem_araddr,
	output logic                   mem_arvalid,
	input  wire                    mem_arready,
	input  wire                    mem_rvalid,
	input  wire fetch_pkg::resp_t  mem_rresp,

	output logic                   lookup,
	output logic                   fill,
	output fetch_pkg::inst_t       fill_data,

	output fetch_pkg::inst_t       inst,
	output logic                   idu_valid,
	output logic                   fetch_error,

	output logic                   count_hit,
	output logic                   count_miss
);
	import fetch_pkg::*;

	fetch_state_t state;
	fetch_state_t state_next;
	logic         rd_done;
	logic         rd_err;

	assign rd_done = (state == MEM_WAIT) && mem_rvalid;
	assign rd_err  = mem_rresp[RESP_ERR_BIT];

	assign mem_araddr  = pc;
	assign mem_arvalid = (state == MEM_REQ);
	assign lookup      = (state == LOOKUP);
	assign fill        = (state == FILL);
	assign count_hit   = (state == CHECK) && cache_hit;
	assign count_miss  = (state == CHECK) && cache_miss;

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (wb_valid) begin
					state_next = in_sram ? MEM_REQ : LOOKUP;
				end
			end
			LOOKUP: state_next = CHECK;
			// The cache answers with exactly one of hit or miss here
			CHECK: state_next = cache_hit ? DELIVER : MEM_REQ;
			MEM_REQ: begin
				if (mem_arready) begin
					state_next = MEM_WAIT;
				end
			end
			MEM_WAIT: begin
				if (mem_rvalid) begin
					state_next = (rd_err || in_sram) ? DELIVER : FILL;
				end
			end
			FILL: state_next = DELIVER;
			DELIVER: state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state       <= IDLE;
			idu_valid   <= 1'b0;
			fetch_error <= 1'b0;
		end else begin
			state       <= state_next;
			idu_valid   <= ((state == CHECK) && cache_hit) ||
			               (rd_done && in_sram && !rd_err) ||
			               (state == FILL);
			fetch_error <= rd_done && rd_err;
		end
	end

	// Word of the last good beat waits here for the fill cycle
	always_ff @(posedge clock) begin
		if (rd_done) begin
			fill_data <= sel_word;
		end
	end

	always_ff @(posedge clock) begin
		if ((state == CHECK) && cache_hit) begin
			inst <= cache_data;
		end else if (rd_done && in_sram && !rd_err) begin
			inst <= sel_word;
		end else if (state == FILL) begin
			inst <= fill_data;
		end
	end

	// Request must hold until the memory takes it
	assert property (@(posedge clock) disable iff (!rst_n)
		mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr));

	assert property (@(posedge clock) disable iff (!rst_n)
		!(idu_valid && fetch_error));

	assert property (@(posedge clock) disable iff (!rst_n)
		idu_valid |=> !idu_valid);

endmodule

`default_nettype wire

// ==== icache/icache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_array #(
	parameter int CACHE_LINES = 16
) (
	input  wire                   clock,
	input  wire                   rst_n,

	input  wire                   lookup,
	input  wire                   fill,
	input  wire fetch_pkg::addr_t addr,
	input  wire fetch_pkg::inst_t fill_data,

	output logic                  hit,
	output logic                  miss,
	output fetch_pkg::inst_t      data
);
	import fetch_pkg::*;
	import cache_pkg::*;

	localparam int INDEX_W = $clog2(CACHE_LINES);

	index_t                   idx;
	logic [INDEX_W-1:0]       line;
	tag_t                     tag;
	logic                     tag_match;

	logic [CACHE_LINES-1:0]   line_valid;
	tag_t                     tag_mem [CACHE_LINES];
	inst_t                    data_mem [CACHE_LINES];

	assign idx  = addr[LINE_BYTES_LOG +: INDEX_MAX_W];
	assign line = idx[INDEX_W-1:0];

	// Index bits are shifted out of the tag
	assign tag = addr[ADDR_W-1:LINE_BYTES_LOG] >> INDEX_W;

	assign tag_match = line_valid[line] && (tag_mem[line] == tag);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			line_valid <= '0;
		end else if (fill) begin
			line_valid[line] <= 1'b1;
		end
	end

	// Result of a lookup is visible for exactly one cycle
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			hit  <= 1'b0;
			miss <= 1'b0;
		end else begin
			hit  <= lookup && tag_match;
			miss <= lookup && !tag_match;
		end
	end

	always_ff @(posedge clock) begin
		if (fill) begin
			tag_mem[line]  <= tag;
			data_mem[line] <= fill_data;
		end
		if (lookup) begin
			data <= data_mem[line];
		end
	end

	// The controller never reads and writes the array in one cycle
	assert property (@(posedge clock) disable iff (!rst_n)
		!(lookup && fill));

endmodule

`default_nettype wire

// ==== logic/fetch_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_counters (
	input  wire               clock,
	input  wire               rst_n,

	input  wire               count_hit,
	input  wire               count_miss,

	output fetch_pkg::count_t hit_count,
	output fetch_pkg::count_t miss_count
);
	import fetch_pkg::*;

	// Both counters stick at their top value
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			hit_count <= '0;
		end else if (count_hit && (hit_count != COUNT_MAX)) begin
			hit_count <= hit_count + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			miss_count <= '0;
		end else if (count_miss && (miss_count != COUNT_MAX)) begin
			miss_count <= miss_count + 1'b1;
		end
	end

	// A lookup resolves to either a hit or a miss
	assert property (@(posedge clock) disable iff (!rst_n)
		!(count_hit && count_miss));

endmodule

`default_nettype wire

// ==== logic/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
	parameter int CACHE_LINES = 16
) (
	input  wire                   clock,
	input  wire                   rst_n,

	input  wire                   wb_valid,
	input  wire fetch_pkg::addr_t pc,

	output fetch_pkg::inst_t      inst,
	output logic                  idu_valid,
	output logic                  fetch_error,

	output fetch_pkg::addr_t      mem_araddr,
	output logic                  mem_arvalid,
	input  wire                   mem_arready,
	input  wire fetch_pkg::beat_t mem_rdata,
	input  wire fetch_pkg::resp_t mem_rresp,
	input  wire                   mem_rvalid,
	output logic                  mem_rready,

	output fetch_pkg::count_t     hit_count,
	output fetch_pkg::count_t     miss_count
);
	import fetch_pkg::*;

	logic  in_sram;
	inst_t sel_word;
	logic  cache_hit;
	logic  cache_miss;
	inst_t cache_data;
	logic  lookup;
	logic  fill;
	inst_t fill_data;
	logic  count_hit;
	logic  count_miss;

	// Beats are always taken in the cycle they arrive
	assign mem_rready = 1'b1;

	fetch_ctrl i_fetch_ctrl (
		.clock       (clock),
		.rst_n       (rst_n),
		.wb_valid    (wb_valid),
		.pc          (pc),
		.in_sram     (in_sram),
		.cache_hit   (cache_hit),
		.cache_miss  (cache_miss),
		.cache_data  (cache_data),
		.sel_word    (sel_word),
		.mem_araddr  (mem_araddr),
		.mem_arvalid (mem_arvalid),
		.mem_arready (mem_arready),
		.mem_rvalid  (mem_rvalid),
		.mem_rresp   (mem_rresp),
		.lookup      (lookup),
		.fill        (fill),
		.fill_data   (fill_data),
		.inst        (inst),
		.idu_valid   (idu_valid),
		.fetch_error (fetch_error),
		.count_hit   (count_hit),
		.count_miss  (count_miss)
	);

	inst_select i_inst_select (
		.pc       (pc),
		.rdata    (mem_rdata),
		.in_sram  (in_sram),
		.sel_word (sel_word)
	);

	icache_array #(
		.CACHE_LINES (CACHE_LINES)
	) i_icache_array (
		.clock     (clock),
		.rst_n     (rst_n),
		.lookup    (lookup),
		.fill      (fill),
		.addr      (pc),
		.fill_data (fill_data),
		.hit       (cache_hit),
		.miss      (cache_miss),
		.data      (cache_data)
	);

	fetch_counters i_fetch_counters (
		.clock      (clock),
		.rst_n      (rst_n),
		.count_hit  (count_hit),
		.count_miss (count_miss),
		.hit_count  (hit_count),
		.miss_count (miss_count)
	);

endmodule

`default_nettype wire

// ==== bench/fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;
	import fetch_pkg::*;

	localparam int CACHE_LINES = 16;
	localparam int RESET_CYCLES = 16;
	localparam int CYCLES_PER_CASE = 40;
	localparam int MAX_CASES = 64;
	localparam addr_t SRAM_LO = 32'h0f000000;
	localparam addr_t SRAM_HI = 32'h0f002000;

	logic   clock;
	logic   rst_n;
	logic   wb_valid;
	addr_t  pc;
	inst_t  inst;
	logic   idu_valid;
	logic   fetch_error;
	addr_t  mem_araddr;
	logic   mem_arvalid;
	logic   mem_arready;
	beat_t  mem_rdata;
	resp_t  mem_rresp;
	logic   mem_rvalid;
	logic   mem_rready;
	count_t hit_count;
	count_t miss_count;

	// Each entry packs pc, kind and error flag as laid out in the cases file
	logic [39:0] case_mem [MAX_CASES];
	int unsigned num_cases;
	logic [31:0] lfsr_state;
	logic        model_err;
	int unsigned read_count;
	addr_t       read_addr;

	fetch_top #(
		.CACHE_LINES (CACHE_LINES)
	) i_fetch_top (
		.clock       (clock),
		.rst_n       (rst_n),
		.wb_valid    (wb_valid),
		.pc          (pc),
		.inst        (inst),
		.idu_valid   (idu_valid),
		.fetch_error (fetch_error),
		.mem_araddr  (mem_araddr),
		.mem_arvalid (mem_arvalid),
		.mem_arready (mem_arready),
		.mem_rdata   (mem_rdata),
		.mem_rresp   (mem_rresp),
		.mem_rvalid  (mem_rvalid),
		.mem_rready  (mem_rready),
		.hit_count   (hit_count),
		.miss_count  (miss_count)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic logic [31:0] rand_bits(int unsigned n);
		logic [31:0] value;
		logic        fb;
		value = '0;
		for (int unsigned k = 0; k < n; k++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	// Memory word is the address XOR 5a5a0000 rotated left by a[4:2]
	function automatic inst_t model_word(addr_t a);
		logic [31:0] x;
		int unsigned r;
		x = a ^ 32'h5a5a0000;
		r = a[4:2];
		return (x << r) | (x >> (32 - r));
	endfunction

	function automatic beat_t read_beat(addr_t a);
		addr_t pair;
		pair = {a[31:3], 3'b000};
		if (a >= SRAM_LO && a < SRAM_HI) begin
			return {model_word(pair + 32'd4), model_word(pair)};
		end
		return {rand_bits(32), model_word(a)};
	endfunction

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic run_fetch(addr_t fetch_pc, logic [3:0] kind, logic err);
		int unsigned cycles;
		int unsigned reads_before;
		reads_before = read_count;
		model_err = err;
		@(posedge clock);
		wb_valid <= 1'b1;
		pc <= fetch_pc;
		@(posedge clock);
		wb_valid <= 1'b0;
		cycles = 0;
		do begin
			@(posedge clock);
			cycles++;
		end while (!idu_valid && !fetch_error);
		check_value("fetch_error", 32'(fetch_error), 32'(err));
		check_value("idu_valid", 32'(idu_valid), 32'(!err));
		if (!err) begin
			check_value("inst", inst, model_word(fetch_pc));
		end
		if (kind == 4'd0) begin
			check_value("hit latency", cycles, 32'd3);
			check_value("memory reads", read_count - reads_before, 32'd0);
		end else begin
			check_value("memory reads", read_count - reads_before, 32'd1);
			check_value("mem_araddr", read_addr, fetch_pc);
		end
	endtask

	// Slave side of the read channel with random arready and rvalid delays
	initial begin : memory_model
		int unsigned ar_delay;
		int unsigned r_delay;
		addr_t       req_addr;
		forever begin
			@(posedge clock);
			if (rst_n && mem_arvalid) begin
				req_addr = mem_araddr;
				ar_delay = rand_bits(3);
				repeat (ar_delay) begin
					@(posedge clock);
					check_value("mem_arvalid", 32'(mem_arvalid), 32'h1);
					check_value("mem_araddr", mem_araddr, req_addr);
				end
				mem_arready <= 1'b1;
				@(posedge clock);
				check_value("mem_arvalid", 32'(mem_arvalid), 32'h1);
				check_value("mem_araddr", mem_araddr, req_addr);
				mem_arready <= 1'b0;
				read_count = read_count + 1;
				read_addr = req_addr;
				r_delay = rand_bits(3);
				repeat (r_delay) @(posedge clock);
				mem_rvalid <= 1'b1;
				mem_rresp <= model_err ? 2'b10 : 2'b00;
				mem_rdata <= read_beat(req_addr);
				@(posedge clock);
				mem_rvalid <= 1'b0;
				mem_rresp <= 2'b00;
				mem_rdata <= '0;
			end
		end
	end

	initial begin : watchdog
		wait (num_cases != 0);
		repeat (num_cases * CYCLES_PER_CASE + RESET_CYCLES) @(posedge clock);
		$display("A fetch timed out, the cases did not finish in time");
		$display("SOME TESTS FAILED");
		$fatal(1);
	end

	initial begin : run_cases
		int unsigned n;
		int unsigned exp_hits;
		int unsigned exp_misses;
		addr_t       case_pc;
		logic [3:0]  case_kind;
		logic        case_err;
		lfsr_state = 32'hbb7f;
		read_count = 0;
		read_addr = '0;
		model_err = 1'b0;
		rst_n = 1'b0;
		wb_valid = 1'b0;
		pc = '0;
		mem_arready = 1'b0;
		mem_rvalid = 1'b0;
		mem_rdata = '0;
		mem_rresp = '0;
		exp_hits = 0;
		exp_misses = 0;
		for (int i = 0; i < MAX_CASES; i++) begin
			case_mem[i] = '1;
		end
		$readmemh("bench/fetch_cases.txt", case_mem);
		n = 0;
		while (n < MAX_CASES && case_mem[n] !== '1) begin
			n++;
		end
		if (n == 0) begin
			$display("No fetch cases could be read from bench/fetch_cases.txt");
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
		num_cases = n;

		repeat (RESET_CYCLES) @(posedge clock);
		rst_n <= 1'b1;
		@(posedge clock);
		check_value("mem_rready", 32'(mem_rready), 32'h1);

		for (int i = 0; i < num_cases; i++) begin
			case_pc = case_mem[i][39:8];
			case_kind = case_mem[i][7:4];
			case_err = case_mem[i][0];
			if (case_kind == 4'd0) begin
				exp_hits++;
			end else if (case_kind == 4'd1) begin
				exp_misses++;
			end
			run_fetch(case_pc, case_kind, case_err);
		end

		@(posedge clock);
		check_value("hit_count", 32'(hit_count), exp_hits);
		check_value("miss_count", 32'(miss_count), exp_misses);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/fetch_cases.txt ====
// pc_kind_err per line: 32-bit pc, kind (0 hit, 1 miss, 2 SRAM), err (1 gives an error response)
// Cache index is pc[5:2], the tag is everything above it
00001000_1_0
00001000_0_0
00001004_1_0
00001004_0_0
00002000_1_0
00001000_1_0
00001000_0_0
00002000_1_0
0f000000_2_0
0f000004_2_0
0f000004_2_0
0f001ff8_2_0
0f001ffc_2_0
00003008_1_1
00003008_1_0
00003008_0_0
0f000010_2_1
0efffffc_1_0
0f002000_1_0
00002000_1_0
00001004_0_0
0efffffc_0_0

// ==== sources.f ====
common/fetch_pkg.sv
common/cache_pkg.sv
fetch/inst_select.sv
fetch/fetch_ctrl.sv
icache/icache_array.sv
logic/fetch_counters.sv
logic/fetch_top.sv
bench/fetch_tb.sv
